// ==== design/dmem_pkg.sv ====
/* Shared request and response types for the data memory path.
   No stall signal exists, so every accepted request is answered one cycle later */

package dmem_pkg;

    ////////////////////////////////////////////////////////////
    // Wishbone request from the core's data adapter
    ////////////////////////////////////////////////////////////

    // A request is accepted in every cycle with cyc and stb high
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [31:0] adr;
        logic [31:0] dat;
        logic [3:0]  sel;
    } wb_req_t;

    ////////////////////////////////////////////////////////////
    // Wishbone response back to the core
    ////////////////////////////////////////////////////////////

    // Read data is 0 on writes and on idle cycles
    typedef struct packed {
        logic        ack;
        logic        err;
        logic [31:0] dat;
    } wb_rsp_t;

    ////////////////////////////////////////////////////////////
    // Response source
    ////////////////////////////////////////////////////////////

    // Which source answers in the cycle after acceptance
    typedef enum logic [1:0] {
        SEL_NONE    = 2'd0,
        SEL_REGION0 = 2'd1,
        SEL_REGION1 = 2'd2,
        SEL_INVALID = 2'd3
    } region_sel_e;

    // Read data returned with err for unmapped addresses
    localparam logic [31:0] ERR_DATA = 32'hDEAD_BEEF;

endpackage

// ==== design/data_memory_selector.sv ====
/* Routes core requests to two address regions and steers responses back.
   Region 0 wins on overlap. Sizes must be multiples of 4 and must not wrap past 2^32.
   Responses are registered by selection, so each arrives exactly one cycle after acceptance */

`timescale 1ns/1ps

module data_memory_selector
    import dmem_pkg::*;
#(
    parameter logic [31:0] REGION0_BASE = 32'h8000_0000,
    parameter logic [31:0] REGION0_SIZE = 32'h0000_1000,
    parameter logic [31:0] REGION1_BASE = 32'h8001_0000,
    parameter logic [31:0] REGION1_SIZE = 32'h0001_0000
) (
    input  logic        clk,
    input  logic        rst_n,

    // Core side
    input  wb_req_t     core_req_i,
    output wb_rsp_t     core_rsp_o,

    // Region 0 memory
    output wb_req_t     region0_req_o,
    input  logic        region0_ack_i,
    input  logic [31:0] region0_dat_i,

    // Region 1 memory
    output wb_req_t     region1_req_o,
    input  logic        region1_ack_i,
    input  logic [31:0] region1_dat_i
);

    // Last byte address of each region
    localparam logic [31:0] REGION0_LAST = REGION0_BASE + REGION0_SIZE - 32'd1;
    localparam logic [31:0] REGION1_LAST = REGION1_BASE + REGION1_SIZE - 32'd1;

    logic        req_accept;
    logic        in_region0;
    logic        in_region1;
    region_sel_e sel_d;
    region_sel_e sel_q;

    ////////////////////////////////////////////////////////////
    // Address decode
    ////////////////////////////////////////////////////////////

    assign req_accept = core_req_i.cyc && core_req_i.stb;

    assign in_region0 = (core_req_i.adr >= REGION0_BASE) && (core_req_i.adr <= REGION0_LAST);
    assign in_region1 = (core_req_i.adr >= REGION1_BASE) && (core_req_i.adr <= REGION1_LAST);

    always_comb begin
        if (!req_accept) begin
            sel_d = SEL_NONE;
        end else if (in_region0) begin
            // Region 0 has priority when the maps overlap
            sel_d = SEL_REGION0;
        end else if (in_region1) begin
            sel_d = SEL_REGION1;
        end else begin
            sel_d = SEL_INVALID;
        end
    end

    ////////////////////////////////////////////////////////////
    // Request routing
    ////////////////////////////////////////////////////////////

    // Unselected region sees an all-zero request
    always_comb begin
        region0_req_o = '0;
        region1_req_o = '0;
        if (sel_d == SEL_REGION0) begin
            region0_req_o     = core_req_i;
            region0_req_o.adr = core_req_i.adr - REGION0_BASE;
        end
        if (sel_d == SEL_REGION1) begin
            region1_req_o     = core_req_i;
            region1_req_o.adr = core_req_i.adr - REGION1_BASE;
        end
    end

    ////////////////////////////////////////////////////////////
    // Response steering
    ////////////////////////////////////////////////////////////

    // Source of next cycle's response
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sel_q <= SEL_NONE;
        end else begin
            sel_q <= sel_d;
        end
    end

    always_comb begin
        core_rsp_o = '0;
        case (sel_q)
            SEL_REGION0: begin
                core_rsp_o.ack = region0_ack_i;
                core_rsp_o.dat = region0_dat_i;
            end
            SEL_REGION1: begin
                core_rsp_o.ack = region1_ack_i;
                core_rsp_o.dat = region1_dat_i;
            end
            SEL_INVALID: begin
                // Unmapped access, nothing was written
                core_rsp_o.ack = 1'b1;
                core_rsp_o.err = 1'b1;
                core_rsp_o.dat = ERR_DATA;
            end
            default: begin
                core_rsp_o = '0;
            end
        endcase
    end

endmodule

// ==== design/wb_region_sram.sv ====
/* Single-port byte-writable word memory with a one-cycle acknowledge.
   Local address must be below DEPTH_WORDS*4. Contents are not reset; writes return data 0 */

`timescale 1ns/1ps

module wb_region_sram
    import dmem_pkg::*;
#(
    parameter int DEPTH_WORDS = 1024
) (
    input  logic        clk,
    input  logic        rst_n,
    input  wb_req_t     req_i,
    output logic        ack_o,
    output logic [31:0] dat_o
);

    // Word index width, at least one bit
    localparam int IDX_W = (DEPTH_WORDS > 1) ? $clog2(DEPTH_WORDS) : 1;

    logic [31:0]      mem [DEPTH_WORDS];
    logic [IDX_W-1:0] word_idx;
    logic             req_accept;
    logic             ack_q;
    logic [31:0]      rdata_q;

    assign req_accept = req_i.cyc && req_i.stb;

    // Byte offset bits dropped
    assign word_idx = req_i.adr[IDX_W+1:2];

    ////////////////////////////////////////////////////////////
    // Storage
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (req_accept && req_i.we) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (req_i.sel[lane]) begin
                    mem[word_idx][lane*8 +: 8] <= req_i.dat[lane*8 +: 8];
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Response
    ////////////////////////////////////////////////////////////

    // Read data held between requests
    always_ff @(posedge clk) begin
        if (req_accept) begin
            rdata_q <= req_i.we ? 32'h0 : mem[word_idx];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= req_accept;
        end
    end

    assign ack_o = ack_q;
    assign dat_o = rdata_q;

endmodule

// ==== design/dmem_subsystem.sv ====
/* Data memory subsystem with a selector and two on-chip regions.
   Region sizes are given in bytes and must be multiples of 4 */

`timescale 1ns/1ps

module dmem_subsystem
    import dmem_pkg::*;
#(
    parameter logic [31:0] REGION0_BASE = 32'h8000_0000,
    parameter logic [31:0] REGION0_SIZE = 32'h0000_1000,
    parameter logic [31:0] REGION1_BASE = 32'h8001_0000,
    parameter logic [31:0] REGION1_SIZE = 32'h0001_0000
) (
    input  logic    clk,
    input  logic    rst_n,
    input  wb_req_t core_req_i,
    output wb_rsp_t core_rsp_o
);

    // Word depth of each region
    localparam int REGION0_DEPTH = int'(REGION0_SIZE >> 2);
    localparam int REGION1_DEPTH = int'(REGION1_SIZE >> 2);

    wb_req_t     region0_req;
    logic        region0_ack;
    logic [31:0] region0_dat;
    wb_req_t     region1_req;
    logic        region1_ack;
    logic [31:0] region1_dat;

    data_memory_selector #(
        .REGION0_BASE (REGION0_BASE),
        .REGION0_SIZE (REGION0_SIZE),
        .REGION1_BASE (REGION1_BASE),
        .REGION1_SIZE (REGION1_SIZE)
    ) u_selector (
        .clk           (clk),
        .rst_n         (rst_n),
        .core_req_i    (core_req_i),
        .core_rsp_o    (core_rsp_o),
        .region0_req_o (region0_req),
        .region0_ack_i (region0_ack),
        .region0_dat_i (region0_dat),
        .region1_req_o (region1_req),
        .region1_ack_i (region1_ack),
        .region1_dat_i (region1_dat)
    );

    wb_region_sram #(
        .DEPTH_WORDS (REGION0_DEPTH)
    ) u_region0 (
        .clk   (clk),
        .rst_n (rst_n),
        .req_i (region0_req),
        .ack_o (region0_ack),
        .dat_o (region0_dat)
    );

    wb_region_sram #(
        .DEPTH_WORDS (REGION1_DEPTH)
    ) u_region1 (
        .clk   (clk),
        .rst_n (rst_n),
        .req_i (region1_req),
        .ack_o (region1_ack),
        .dat_o (region1_dat)
    );

endmodule

// ==== verif/tb_clock_gen.sv ====
/* Free-running testbench clock, low at time zero */

`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS = 100
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
    end

    // Toggle every half period
    always begin
        #(PERIOD_NS / 2.0);
        clk_o = ~clk_o;
    end

endmodule

// ==== verif/dmem_checker.sv ====
/* Response timing assertions, bound into data_memory_selector.
   A request counts as accepted whenever cyc and stb are both high */

`timescale 1ns/1ps

module dmem_checker
    import dmem_pkg::*;
(
    input logic        clk,
    input logic        rst_n,
    input wb_req_t     core_req_i,
    input wb_rsp_t     core_rsp_i,
    input region_sel_e sel_i,
    input logic        region0_ack_i,
    input logic        region1_ack_i
);

    // Number of failed assertions
    int unsigned fail_count = 0;

    // No response in the first cycle out of reset
    idle_after_reset: assert property (@(posedge clk)
        $rose(rst_n) |-> !core_rsp_i.ack && !core_rsp_i.err && (sel_i == SEL_NONE))
    else begin
        $error("ack or err high in the first cycle after reset release");
        fail_count++;
    end

    // One response, one cycle after acceptance
    ack_next_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        (core_req_i.cyc && core_req_i.stb) |=> core_rsp_i.ack && (sel_i != SEL_NONE))
    else begin
        $error("accepted request was not acknowledged in the next cycle");
        fail_count++;
    end

    // An unmapped request never reaches a memory
    err_with_ack: assert property (@(posedge clk) disable iff (!rst_n)
        core_rsp_i.err |-> core_rsp_i.ack && !region0_ack_i && !region1_ack_i)
    else begin
        $error("err high without ack or together with a memory acknowledge");
        fail_count++;
    end

endmodule

bind data_memory_selector dmem_checker u_checker (
    .clk           (clk),
    .rst_n         (rst_n),
    .core_req_i    (core_req_i),
    .core_rsp_i    (core_rsp_o),
    .sel_i         (sel_q),
    .region0_ack_i (region0_ack_i),
    .region1_ack_i (region1_ack_i)
);

// ==== verif/tb_dmem.sv ====
/* Testbench for the data memory subsystem, driven by verif/dmem_golden.txt.
   Must run from the project root; stops at the first mismatch */

`timescale 1ns/1ps

module tb_dmem
    import dmem_pkg::*;
();

    localparam int    CLK_PERIOD  = 100;
    localparam string GOLDEN_FILE = "verif/dmem_golden.txt";

    // One golden line
    typedef struct packed {
        logic        cyc;
        logic        we;
        logic [31:0] adr;
        logic [31:0] dat;
        logic [3:0]  sel;
        logic        err;
        logic [31:0] rdata;
    } vector_t;

    logic    clk;
    logic    rst_n;
    wb_req_t core_req;
    wb_rsp_t core_rsp;

    vector_t vectors[$];
    wb_rsp_t expected_q[$];
    bit      vectors_loaded = 1'b0;

    tb_clock_gen #(.PERIOD_NS(CLK_PERIOD)) u_clock_gen (.clk_o(clk));

    dmem_subsystem #(
        .REGION0_BASE (32'h8000_0000),
        .REGION0_SIZE (32'h0000_1000),
        .REGION1_BASE (32'h8001_0000),
        .REGION1_SIZE (32'h0001_0000)
    ) UUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .core_req_i (core_req),
        .core_rsp_o (core_rsp)
    );

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////

    task automatic abort_run();
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("ERR time=%0t %s got 0x%08h expected 0x%08h",
                     $time, name, actual, expected);
            abort_run();
        end
    endtask

    task automatic check_response(input wb_rsp_t exp_rsp);
        check_value("core_rsp_o.ack", {31'b0, core_rsp.ack}, {31'b0, exp_rsp.ack});
        check_value("core_rsp_o.err", {31'b0, core_rsp.err}, {31'b0, exp_rsp.err});
        check_value("core_rsp_o.dat", core_rsp.dat, exp_rsp.dat);
    endtask

    // Lines that do not start with a number are skipped as comments
    task automatic load_vectors();
        int               fd;
        int               code;
        logic [31:0]      f_cyc;
        logic [31:0]      f_we;
        logic [31:0]      f_adr;
        logic [31:0]      f_dat;
        logic [31:0]      f_sel;
        logic [31:0]      f_err;
        logic [31:0]      f_rdata;
        logic [8*160-1:0] skipped;
        vector_t          vec;
        fd = $fopen(GOLDEN_FILE, "r");
        if (fd == 0) begin
            $display("Cannot open golden file %s", GOLDEN_FILE);
            abort_run();
        end
        while (!$feof(fd)) begin
            code = $fscanf(fd, " %h %h %h %h %h %h %h",
                           f_cyc, f_we, f_adr, f_dat, f_sel, f_err, f_rdata);
            if (code == 7) begin
                vec = {f_cyc[0], f_we[0], f_adr, f_dat, f_sel[3:0], f_err[0], f_rdata};
                vectors.push_back(vec);
            end else if (code <= 0) begin
                code = $fgets(skipped, fd);
            end else begin
                $display("Malformed golden line after vector %0d", vectors.size());
                abort_run();
            end
        end
        $fclose(fd);
        if (vectors.size() == 0) begin
            $display("Golden file holds no vectors");
            abort_run();
        end
        vectors_loaded = 1'b1;
    endtask

    task automatic drive_vector(input vector_t vec);
        wb_rsp_t exp_rsp;
        core_req.cyc = vec.cyc;
        core_req.stb = vec.cyc;
        core_req.we  = vec.we;
        core_req.adr = vec.adr;
        core_req.dat = vec.dat;
        core_req.sel = vec.sel;
        // Idle cycles answer with all zero
        exp_rsp = '0;
        if (vec.cyc) begin
            exp_rsp.ack = 1'b1;
            exp_rsp.err = vec.err;
            exp_rsp.dat = vec.rdata;
        end
        expected_q.push_back(exp_rsp);
    endtask

    ////////////////////////////////////////////////////////////
    // Stimulus and checking on the falling edge
    ////////////////////////////////////////////////////////////

    initial begin : stimulus
        core_req = '0;
        rst_n    = 1'b0;
        load_vectors();
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        foreach (vectors[i]) begin
            @(negedge clk);
            if (expected_q.size() > 0) begin
                check_response(expected_q.pop_front());
            end
            drive_vector(vectors[i]);
        end
        @(negedge clk);
        check_response(expected_q.pop_front());
        core_req = '0;
        @(negedge clk);
        if (UUT.u_selector.u_checker.fail_count != 0) begin
            $display("Assertion checker saw %0d failures",
                     UUT.u_selector.u_checker.fail_count);
            abort_run();
        end else begin
            $display("Regression passed");
            $finish;
        end
    end

    initial begin : watchdog
        longint limit_ns;
        wait (vectors_loaded);
        limit_ns = (vectors.size() + 10) * CLK_PERIOD;
        #(limit_ns);
        $display("Run timed out after %0d ns", limit_ns);
        abort_run();
    end

endmodule

// ==== verif/dmem_golden.txt ====
# cyc we address wdata sel exp_err exp_rdata, all hex, one request per line
# cyc 0 is an idle cycle; writes expect rdata 0, unmapped expects deadbeef
0 0 00000000 00000000 0 0 00000000
0 0 00000000 00000000 0 0 00000000
0 0 00000000 00000000 0 0 00000000
# region 0 lowest and highest word
1 1 80000000 11223344 f 0 00000000
1 1 80000ffc a5a5c3c3 f 0 00000000
1 0 80000000 00000000 f 0 11223344
1 0 80000ffc 00000000 f 0 a5a5c3c3
# region 1 byte lanes
1 1 80010010 11111111 f 0 00000000
1 1 80010010 aabbccdd 5 0 00000000
1 0 80010010 00000000 f 0 11bb11dd
1 1 80010010 eeff0000 8 0 00000000
1 0 80010010 00000000 f 0 eebb11dd
1 1 80010000 0badc0de f 0 00000000
0 0 00000000 00000000 0 0 00000000
# unmapped: below region 0, past region 0, past region 1
1 1 7ffffffc cafef00d f 1 deadbeef
1 1 80001000 cafef00d f 1 deadbeef
1 1 80020000 cafef00d f 1 deadbeef
1 0 80000ffc 00000000 f 0 a5a5c3c3
1 0 80000000 00000000 f 0 11223344
1 0 80010000 00000000 f 0 0badc0de
1 0 80020000 00000000 f 1 deadbeef
# back to back across region 0, region 1 and unmapped
1 1 80000040 40404040 f 0 00000000
1 1 80010040 41414141 f 0 00000000
1 1 90000000 12345678 f 1 deadbeef
1 0 80000040 00000000 f 0 40404040
1 0 80010040 00000000 f 0 41414141
1 0 00000000 00000000 f 1 deadbeef
1 1 80000080 87654321 f 0 00000000
1 0 80000080 00000000 f 0 87654321
# same local offset in both regions
1 1 80000010 01010101 f 0 00000000
1 1 80010020 33333333 f 0 00000000
1 1 80000020 22222222 f 0 00000000
1 0 80000010 00000000 f 0 01010101
1 0 80010010 00000000 f 0 eebb11dd
1 0 80000020 00000000 f 0 22222222
1 0 80010020 00000000 f 0 33333333
0 0 00000000 00000000 0 0 00000000

// ==== verilog.f ====
design/dmem_pkg.sv
design/data_memory_selector.sv
design/wb_region_sram.sv
design/dmem_subsystem.sv
verif/tb_clock_gen.sv
verif/dmem_checker.sv
verif/tb_dmem.sv

// ==== Bender.yml ====
package:
  name: dmem_subsystem

sources:
  - design/dmem_pkg.sv
  - design/data_memory_selector.sv
  - design/wb_region_sram.sv
  - design/dmem_subsystem.sv
  - target: simulation
    files:
      - verif/tb_clock_gen.sv
      - verif/dmem_checker.sv
      - verif/tb_dmem.sv
